// ==== common/cdc_fifo_config.svh ====
`ifndef CDC_FIFO_CONFIG_SVH
`define CDC_FIFO_CONFIG_SVH

// Number of FIFO entries
// Keep this a power of two so the Gray counts wrap without a jump
`define FIFO_DEPTH 8

// Width of one payload word in bits
`define FIFO_WIDTH 16

// Flops per clock domain crossing of a Gray count
`define FIFO_SYNC_STAGES 2

`endif

// ==== common/fifo_data_pkg.sv ====
package fifo_data_pkg;

  `include "cdc_fifo_config.svh"

  // ----------------------------------------------------------
  // Payload
  // ----------------------------------------------------------

  // One word as it enters on the push side and leaves on the pop side
  // The FIFO never looks inside it
  typedef logic [`FIFO_WIDTH-1:0] fifo_data_t;

endpackage : fifo_data_pkg

// ==== common/fifo_ptr_pkg.sv ====
package fifo_ptr_pkg;

  `include "cdc_fifo_config.svh"

  // ----------------------------------------------------------
  // Pointers and counts
  // ----------------------------------------------------------

  localparam int addr_width = $clog2(`FIFO_DEPTH);

  // Index into the storage RAM
  typedef logic [addr_width-1:0] fifo_addr_t;

  // One extra bit so that a completely full FIFO can be told apart from an empty one
  typedef logic [addr_width:0] fifo_count_t;

  // Same width as a count, but only one bit flips per increment
  typedef logic [addr_width:0] fifo_gray_t;

  // Read sequencing on the pop side
  typedef enum logic [1:0] {
    POP_EMPTY,
    POP_READ,
    POP_HOLD
  } pop_state_t;

  // Binary to Gray is a shift and an XOR
  function automatic fifo_gray_t bin2gray(input fifo_count_t bin);
    return fifo_gray_t'(bin ^ (bin >> 1));
  endfunction

  // Gray to binary ripples down from the MSB
  function automatic fifo_count_t gray2bin(input fifo_gray_t gray);
    fifo_count_t bin;
    bin[addr_width] = gray[addr_width];
    for (int i = addr_width - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage : fifo_ptr_pkg

// ==== hdl/gray_sync.sv ====
`include "cdc_fifo_config.svh"

module gray_sync (
  input  logic                     clk,
  input  logic                     arst_n,
  input  fifo_ptr_pkg::fifo_gray_t gray_in,
  output fifo_ptr_pkg::fifo_gray_t gray_out
);

  // Stage 0 is the metastable capture flop, the last stage feeds the receiving logic
  fifo_ptr_pkg::fifo_gray_t sync_q [`FIFO_SYNC_STAGES];

  // Only one bit of the Gray input moves at a time, so a late capture
  // just delays the count by a cycle instead of corrupting it
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `FIFO_SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= gray_in;
      for (int i = 1; i < `FIFO_SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign gray_out = sync_q[`FIFO_SYNC_STAGES-1];

endmodule : gray_sync

// ==== hdl/fifo_ram_1r1w.sv ====
`include "cdc_fifo_config.svh"

module fifo_ram_1r1w (
  input  logic                     push_clk,
  input  logic                     wr_valid,
  input  fifo_ptr_pkg::fifo_addr_t wr_addr,
  input  fifo_data_pkg::fifo_data_t wr_data,
  input  logic                     pop_clk,
  input  logic                     rd_valid,
  input  fifo_ptr_pkg::fifo_addr_t rd_addr,
  output fifo_data_pkg::fifo_data_t rd_data
);

  import fifo_data_pkg::*;

  // Storage array in flops, written from the push domain only
  fifo_data_t mem [`FIFO_DEPTH];

  // Write port
  // The word is in the array one push cycle after the request
  always_ff @(posedge push_clk) begin
    if (wr_valid) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read port in the pop domain
  // The output register holds its value between reads, so the
  // controller can sample it any time after the cycle of the read
  always_ff @(posedge pop_clk) begin
    if (rd_valid) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule : fifo_ram_1r1w

// ==== cdc_fifo_ctrl/cdc_fifo_ctrl_push.sv ====
`include "cdc_fifo_config.svh"

module cdc_fifo_ctrl_push (
  input  logic                      push_clk,
  input  logic                      arst_n,
  input  logic                      push_valid,
  input  fifo_data_pkg::fifo_data_t push_data,
  output logic                      push_ready,
  output logic                      push_full,
  output fifo_ptr_pkg::fifo_count_t push_slots,
  output logic                      ram_wr_valid,
  output fifo_ptr_pkg::fifo_addr_t  ram_wr_addr,
  output fifo_data_pkg::fifo_data_t ram_wr_data,
  output fifo_ptr_pkg::fifo_gray_t  push_count_gray,
  input  fifo_ptr_pkg::fifo_gray_t  pop_count_gray
);

  import fifo_ptr_pkg::*;

  logic [1:0]  rst_sync_q;
  logic        push_arst_n;
  logic        accept;
  fifo_count_t wr_count;
  fifo_count_t wr_count_next;
  fifo_gray_t  pop_gray_sync;
  fifo_count_t rd_count;

  // ----------------------------------------------------------
  // Reset synchronizer
  // ----------------------------------------------------------

  // Assertion is immediate, release follows two push clocks later
  always_ff @(posedge push_clk or negedge arst_n) begin
    if (!arst_n) begin
      rst_sync_q <= 2'b00;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  // Local reset for everything else in the push domain
  assign push_arst_n = rst_sync_q[1];

  // ----------------------------------------------------------
  // Write count
  // ----------------------------------------------------------

  assign accept        = push_valid & push_ready;
  assign wr_count_next = wr_count + 1'b1;

  // The Gray image moves on the same edge as the RAM write, so the pop
  // side never sees a count ahead of the data it covers
  always_ff @(posedge push_clk or negedge push_arst_n) begin
    if (!push_arst_n) begin
      wr_count        <= '0;
      push_count_gray <= '0;
    end else if (accept) begin
      wr_count        <= wr_count_next;
      push_count_gray <= bin2gray(wr_count_next);
    end
  end

  // ----------------------------------------------------------
  // Pop count crossing and status
  // ----------------------------------------------------------

  gray_sync pop_count_sync_i (
    .clk      (push_clk),
    .arst_n   (push_arst_n),
    .gray_in  (pop_count_gray),
    .gray_out (pop_gray_sync)
  );

  assign rd_count = gray2bin(pop_gray_sync);

  // The synchronized pop count lags, so slots are never overstated
  assign push_slots = fifo_count_t'(`FIFO_DEPTH) - (wr_count - rd_count);
  assign push_full  = (push_slots == '0);

  // Ready stays low until the local reset has released
  assign push_ready = push_arst_n & ~push_full;

  // An accepted word goes straight to the RAM in the same cycle
  assign ram_wr_valid = accept;
  assign ram_wr_addr  = wr_count[addr_width-1:0];
  assign ram_wr_data  = push_data;

endmodule : cdc_fifo_ctrl_push

// ==== cdc_fifo_ctrl/cdc_fifo_ctrl_pop.sv ====
module cdc_fifo_ctrl_pop (
  input  logic                      pop_clk,
  input  logic                      arst_n,
  input  logic                      pop_ready,
  output logic                      pop_valid,
  output fifo_data_pkg::fifo_data_t pop_data,
  output logic                      pop_empty,
  output fifo_ptr_pkg::fifo_count_t pop_items,
  output logic                      ram_rd_valid,
  output fifo_ptr_pkg::fifo_addr_t  ram_rd_addr,
  input  fifo_data_pkg::fifo_data_t ram_rd_data,
  output fifo_ptr_pkg::fifo_gray_t  pop_count_gray,
  input  fifo_ptr_pkg::fifo_gray_t  push_count_gray
);

  import fifo_ptr_pkg::*;
  import fifo_data_pkg::*;

  logic [1:0]  rst_sync_q;
  logic        pop_arst_n;
  logic        pop_fire;
  logic        more_items;
  pop_state_t  state_q;
  pop_state_t  state_d;
  fifo_count_t rd_count;
  fifo_count_t rd_count_next;
  fifo_gray_t  push_gray_sync;
  fifo_count_t wr_count;
  fifo_data_t  stage_q;

  // ----------------------------------------------------------
  // Reset synchronizer
  // ----------------------------------------------------------

  always_ff @(posedge pop_clk or negedge arst_n) begin
    if (!arst_n) begin
      rst_sync_q <= 2'b00;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign pop_arst_n = rst_sync_q[1];

  // ----------------------------------------------------------
  // Push count crossing and status
  // ----------------------------------------------------------

  gray_sync push_count_sync_i (
    .clk      (pop_clk),
    .arst_n   (pop_arst_n),
    .gray_in  (push_count_gray),
    .gray_out (push_gray_sync)
  );

  assign wr_count = gray2bin(push_gray_sync);

  // Items include a word sitting in staging, since the count only
  // advances when that word is handed out
  assign pop_items     = wr_count - rd_count;
  assign pop_empty     = (pop_items == '0);
  assign rd_count_next = rd_count + 1'b1;
  assign more_items    = (wr_count != rd_count_next);

  // ----------------------------------------------------------
  // Read sequencing
  // ----------------------------------------------------------

  assign pop_valid = (state_q == POP_HOLD);
  assign pop_fire  = pop_valid & pop_ready;

  always_comb begin
    state_d      = state_q;
    ram_rd_valid = 1'b0;
    ram_rd_addr  = rd_count[addr_width-1:0];
    case (state_q)
      POP_EMPTY: begin
        if (!pop_empty) begin
          ram_rd_valid = 1'b1;
          state_d      = POP_READ;
        end
      end
      // RAM output is valid this cycle and moves into staging
      POP_READ: begin
        state_d = POP_HOLD;
      end
      POP_HOLD: begin
        // Fetch the next word as this one leaves, if there is one
        if (pop_fire) begin
          if (more_items) begin
            ram_rd_valid = 1'b1;
            ram_rd_addr  = rd_count_next[addr_width-1:0];
            state_d      = POP_READ;
          end else begin
            state_d = POP_EMPTY;
          end
        end
      end
      default: begin
        state_d = POP_EMPTY;
      end
    endcase
  end

  always_ff @(posedge pop_clk or negedge pop_arst_n) begin
    if (!pop_arst_n) begin
      state_q        <= POP_EMPTY;
      rd_count       <= '0;
      pop_count_gray <= '0;
    end else begin
      state_q <= state_d;
      // The freed slot becomes visible to the push side from here
      if (pop_fire) begin
        rd_count       <= rd_count_next;
        pop_count_gray <= bin2gray(rd_count_next);
      end
    end
  end

  // Staging register keeps pop_data steady while the consumer stalls
  always_ff @(posedge pop_clk) begin
    if (state_q == POP_READ) begin
      stage_q <= ram_rd_data;
    end
  end

  assign pop_data = stage_q;

endmodule : cdc_fifo_ctrl_pop

// ==== cdc_fifo_ctrl/cdc_fifo_ctrl.sv ====
module cdc_fifo_ctrl (
  input  logic                      push_clk,
  input  logic                      pop_clk,
  input  logic                      arst_n,
  // Push side
  input  logic                      push_valid,
  input  fifo_data_pkg::fifo_data_t push_data,
  output logic                      push_ready,
  output logic                      push_full,
  output fifo_ptr_pkg::fifo_count_t push_slots,
  output logic                      ram_wr_valid,
  output fifo_ptr_pkg::fifo_addr_t  ram_wr_addr,
  output fifo_data_pkg::fifo_data_t ram_wr_data,
  // Pop side
  input  logic                      pop_ready,
  output logic                      pop_valid,
  output fifo_data_pkg::fifo_data_t pop_data,
  output logic                      pop_empty,
  output fifo_ptr_pkg::fifo_count_t pop_items,
  output logic                      ram_rd_valid,
  output fifo_ptr_pkg::fifo_addr_t  ram_rd_addr,
  input  fifo_data_pkg::fifo_data_t ram_rd_data
);

  import fifo_ptr_pkg::*;

  // Each count is registered in its own domain and synchronized on the far side
  fifo_gray_t push_count_gray;
  fifo_gray_t pop_count_gray;

  cdc_fifo_ctrl_push push_i (
    .push_clk, .arst_n, .push_valid, .push_data, .push_ready, .push_full,
    .push_slots, .ram_wr_valid, .ram_wr_addr, .ram_wr_data,
    .push_count_gray, .pop_count_gray
  );

  cdc_fifo_ctrl_pop pop_i (
    .pop_clk, .arst_n, .pop_ready, .pop_valid, .pop_data, .pop_empty,
    .pop_items, .ram_rd_valid, .ram_rd_addr, .ram_rd_data,
    .pop_count_gray, .push_count_gray
  );

endmodule : cdc_fifo_ctrl

// ==== hdl/cdc_fifo.sv ====
module cdc_fifo (
  input  logic                      push_clk,
  input  logic                      pop_clk,
  input  logic                      arst_n,
  input  logic                      push_valid,
  input  fifo_data_pkg::fifo_data_t push_data,
  output logic                      push_ready,
  output logic                      push_full,
  output fifo_ptr_pkg::fifo_count_t push_slots,
  input  logic                      pop_ready,
  output logic                      pop_valid,
  output fifo_data_pkg::fifo_data_t pop_data,
  output logic                      pop_empty,
  output fifo_ptr_pkg::fifo_count_t pop_items
);

  import fifo_ptr_pkg::*;
  import fifo_data_pkg::*;

  // RAM ports between the controller and the storage
  logic       ram_wr_valid;
  fifo_addr_t ram_wr_addr;
  fifo_data_t ram_wr_data;
  logic       ram_rd_valid;
  fifo_addr_t ram_rd_addr;
  fifo_data_t ram_rd_data;

  cdc_fifo_ctrl ctrl_i (
    .push_clk, .pop_clk, .arst_n,
    .push_valid, .push_data, .push_ready, .push_full, .push_slots,
    .ram_wr_valid, .ram_wr_addr, .ram_wr_data,
    .pop_ready, .pop_valid, .pop_data, .pop_empty, .pop_items,
    .ram_rd_valid, .ram_rd_addr, .ram_rd_data
  );

  // Read latency of one pop cycle matches the staging sequence in the controller
  fifo_ram_1r1w ram_i (
    .push_clk (push_clk),
    .wr_valid (ram_wr_valid),
    .wr_addr  (ram_wr_addr),
    .wr_data  (ram_wr_data),
    .pop_clk  (pop_clk),
    .rd_valid (ram_rd_valid),
    .rd_addr  (ram_rd_addr),
    .rd_data  (ram_rd_data)
  );

endmodule : cdc_fifo

// ==== bench/cdc_fifo_tb.sv ====
`include "cdc_fifo_config.svh"

module cdc_fifo_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import fifo_data_pkg::*;
  import fifo_ptr_pkg::*;

  localparam fifo_count_t depth = fifo_count_t'(`FIFO_DEPTH);
  // Words pushed with the pop side stalled in the count crossing test, below the depth
  localparam int part_words = 5;

  logic        push_clk;
  logic        pop_clk;
  logic        arst_n;
  logic        push_valid;
  fifo_data_t  push_data;
  logic        push_ready;
  logic        push_full;
  fifo_count_t push_slots;
  logic        pop_ready;
  logic        pop_valid;
  fifo_data_t  pop_data;
  logic        pop_empty;
  fifo_count_t pop_items;

  // Reference model holds every accepted word that has not left yet
  fifo_data_t model [$];
  int errors = 0;
  int checks = 0;
  int stall_checks = 0;

  cdc_fifo cdc_fifo_i (
    .push_clk, .pop_clk, .arst_n,
    .push_valid, .push_data, .push_ready, .push_full, .push_slots,
    .pop_ready, .pop_valid, .pop_data, .pop_empty, .pop_items
  );

  // ----------------------------------------------------------
  // Clocks
  // ----------------------------------------------------------

  initial begin
    push_clk = 1'b0;
    forever #4 push_clk = ~push_clk;
  end

  // Pop edges trail the push edges by 3 ns, so the two never line up
  initial begin
    pop_clk = 1'b0;
    #3;
    forever #4 pop_clk = ~pop_clk;
  end

  // ----------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------

  task automatic check_data(input string name, input fifo_data_t exp, input fifo_data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input fifo_count_t exp, input fifo_count_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: FAILED with %0d errors", name, errors - errors_before);
    end
  endtask

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------

  // Waits until push is open and the slot and item counts add up to the depth
  // Pop outputs only move on pop edges, so they are steady at a push negedge
  task automatic settle();
    int  cycles;
    bit  done;
    cycles = 0;
    @(negedge push_clk);
    done = push_ready && (int'(push_slots) + int'(pop_items) == `FIFO_DEPTH);
    while (!done && cycles < 40) begin
      @(negedge push_clk);
      cycles++;
      done = push_ready && (int'(push_slots) + int'(pop_items) == `FIFO_DEPTH);
    end
    if (!done) begin
      errors++;
      $display("Timeout at %0t: push and pop sides did not agree on the fill level", $time);
    end
  endtask

  // Holds each word until accepted; the handshake is judged at the negedge
  // before the edge that takes the word
  task automatic push_words(input int n, input int pct, input bit stop_on_full,
                            output int sent);
    int cycles;
    bit take;
    sent   = 0;
    cycles = 0;
    take   = 1'b0;
    while (sent < n && cycles < 40 * n && !(stop_on_full && push_full)) begin
      @(posedge push_clk);
      #1;
      if (take) begin
        push_valid = 1'b0;
      end
      if (!push_valid && $urandom_range(99) < pct) begin
        push_valid = 1'b1;
        push_data  = fifo_data_t'($urandom);
      end
      @(negedge push_clk);
      cycles++;
      take = push_valid && push_ready;
      if (take) begin
        model.push_back(push_data);
        sent++;
      end
    end
    @(posedge push_clk);
    #1;
    push_valid = 1'b0;
    if (sent < n && !(stop_on_full && push_full)) begin
      errors++;
      $display("Timeout at %0t: push side took only %0d of %0d words", $time, sent, n);
    end
  endtask

  // Random pop_ready; a stalled word must stay valid and unchanged
  task automatic pop_words(input int n, input int pct);
    int         popped;
    int         cycles;
    bit         held;
    fifo_data_t held_data;
    popped    = 0;
    cycles    = 0;
    held      = 1'b0;
    held_data = '0;
    while (popped < n && cycles < 60 * n + 100) begin
      @(posedge pop_clk);
      #1;
      pop_ready = ($urandom_range(99) < pct);
      @(negedge pop_clk);
      cycles++;
      if (held) begin
        stall_checks++;
        check_flag("pop_valid", 1'b1, pop_valid);
        check_data("pop_data", held_data, pop_data);
      end
      if (pop_valid && pop_ready) begin
        if (model.size() == 0) begin
          errors++;
          $display("Error at %0t: a word left the FIFO with the model empty", $time);
        end else begin
          check_data("pop_data", model.pop_front(), pop_data);
        end
        popped++;
      end
      held      = pop_valid && !pop_ready;
      held_data = pop_data;
    end
    @(posedge pop_clk);
    #1;
    pop_ready = 1'b0;
    if (popped < n) begin
      errors++;
      $display("Timeout at %0t: only %0d of %0d words were popped", $time, popped, n);
    end
  endtask

  task automatic check_model_empty();
    if (model.size() != 0) begin
      errors++;
      $display("Error at %0t: %0d words never left the FIFO", $time, model.size());
    end
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------

  initial begin
    int e0;
    int sent;
    int stalls0;
    arst_n     = 1'b0;
    push_valid = 1'b0;
    push_data  = '0;
    pop_ready  = 1'b0;
    void'($urandom(32'h3c6b66ba));

    repeat (4) @(posedge push_clk);
    #1;
    arst_n = 1'b1;
    e0 = errors;
    // The push side is still held by its own reset synchronizer here
    @(negedge push_clk);
    check_flag("push_ready", 1'b0, push_ready);
    check_flag("push_full", 1'b0, push_full);
    check_count("push_slots", depth, push_slots);
    check_flag("pop_valid", 1'b0, pop_valid);
    check_flag("pop_empty", 1'b1, pop_empty);
    check_count("pop_items", '0, pop_items);
    settle();
    report_test("reset state", e0);

    e0 = errors;
    fork
      push_words(500, 70, 1'b0, sent);
      pop_words(500, 60);
    join
    check_model_empty();
    report_test("ordering and integrity", e0);

    // Low pop duty leaves words parked in staging for a while
    e0      = errors;
    stalls0 = stall_checks;
    fork
      push_words(100, 80, 1'b0, sent);
      pop_words(100, 20);
    join
    if (stall_checks == stalls0) begin
      errors++;
      $display("Error: the pop side never stalled with a word waiting");
    end
    report_test("pop back-pressure", e0);

    e0 = errors;
    settle();
    push_words(2 * `FIFO_DEPTH, 100, 1'b1, sent);
    @(negedge push_clk);
    check_count("accepted words", depth, fifo_count_t'(sent));
    check_flag("push_full", 1'b1, push_full);
    check_flag("push_ready", 1'b0, push_ready);
    check_count("push_slots", '0, push_slots);
    pop_words(`FIFO_DEPTH, 100);
    report_test("full", e0);

    // Both counts have to land on the number of words pushed
    e0 = errors;
    settle();
    push_words(part_words, 100, 1'b0, sent);
    settle();
    check_count("push_slots", depth - fifo_count_t'(part_words), push_slots);
    check_count("pop_items", fifo_count_t'(part_words), pop_items);
    check_flag("pop_empty", 1'b0, pop_empty);
    pop_words(part_words, 100);
    report_test("count crossing", e0);

    e0 = errors;
    settle();
    check_flag("pop_empty", 1'b1, pop_empty);
    check_count("pop_items", '0, pop_items);
    check_flag("pop_valid", 1'b0, pop_valid);
    check_count("push_slots", depth, push_slots);
    check_model_empty();
    report_test("drain", e0);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule : cdc_fifo_tb

// ==== cdc_fifo.f ====
+incdir+common
common/fifo_data_pkg.sv
common/fifo_ptr_pkg.sv
hdl/gray_sync.sv
hdl/fifo_ram_1r1w.sv
cdc_fifo_ctrl/cdc_fifo_ctrl_push.sv
cdc_fifo_ctrl/cdc_fifo_ctrl_pop.sv
cdc_fifo_ctrl/cdc_fifo_ctrl.sv
hdl/cdc_fifo.sv
bench/cdc_fifo_tb.sv
